//--- all.f
core_pkg.sv
core_ifs.sv
fetch_stage.sv
instr_decoder.sv
register_file.sv
load_store_unit.sv
exec_stage.sv
core_top.sv
tb_core.sv

//--- core_cases.txt
// Header: boot address, program word count, expected store count
// Then the program words in address order, then expected stores as address data pairs
00000200 00000022 0000000C
// lui x1 / addi x2,-3 / ori x3 / sw x3,0
123450B7 FFD00113 6780E193 00302023
// add x4 / sub x5 / xor x6 / slt x7
00218233 403102B3 00524333 0042A3B3
// sw x4,4 / sw x5,8 / sw x6,12 / sw x7,16
00402223 00502423 00602623 00702823
// andi x8 / xori x9,-1 / slti x10,-100 / or x11
0F01F413 FFF44493 F9C4A513 00A465B3
// and x12 / sw x9,20 / sw x11,24 / sw x12,28
0034F633 00902A23 00B02C23 00C02E23
// addi x0 / lw x13,8 / sw x13,32 / sw x0,36
00508013 00802683 02D02023 02002223
// bne taken / two skipped stores / beq not taken
00039663 02102423 02102623 00038463
// sw x10,48 / jal x14 / two skipped stores
02A02823 00C0076F 02102A23 02102C23
// sw x14,60 / jal x0,0 loop
02E02E23 0000006F
// Expected stores
00000000 12345678 00000004 12345675 00000008 EDCBA985
0000000C FFFFFFF0 00000010 00000001 00000014 FFFFFF8F
00000018 00000071 0000001C 12345608 00000020 EDCBA985
00000024 00000000 00000030 00000001 0000003C 00000278

//--- core_ifs.sv
// Interfaces between fetch and execute, and from execute to the register file
`timescale 1ns/10ps

interface fetch_exec_if;
  import core_pkg::*;

  logic  instr_valid;
  word_t instr;
  word_t pc;
  // Instruction moves on instr_valid and take
  logic  take;
  // One-cycle pulse, buffer is flushed
  logic  redirect;
  word_t redirect_pc;

  modport fetch (output instr_valid, instr, pc, input take, redirect, redirect_pc);
  modport exec  (input instr_valid, instr, pc, output take, redirect, redirect_pc);
endinterface

interface regfile_if;
  import core_pkg::*;

  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  word_t     rdata_a;
  word_t     rdata_b;
  logic      we;
  reg_addr_t waddr;
  word_t     wdata;

  modport exec    (output raddr_a, raddr_b, we, waddr, wdata, input rdata_a, rdata_b);
  modport regfile (input raddr_a, raddr_b, we, waddr, wdata, output rdata_a, rdata_b);
endinterface

//--- core_pkg.sv
// Core package with widths, opcode and ALU encodings and the decoded instruction record
package core_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  // Sequential PC step
  localparam int INSTR_STEP = 4;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // RV32I major opcodes, subset only
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  ////////////////////
  // Decoder output
  ////////////////////
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_e   alu_op;
    // Operand b from immediate
    logic      use_imm;
    logic      we;
    logic      load;
    logic      store;
    logic      branch;
    // BNE when set, else BEQ
    logic      bne;
    logic      jal;
    // Operand a forced to zero
    logic      lui;
  } decoded_t;

endpackage

//--- core_top.sv
// Core top level joining fetch, execute and register file to the memory buses
`timescale 1ns/10ps

module core_top (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,
  // Instruction bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output core_pkg::word_t instr_addr_o,
  input  core_pkg::word_t instr_rdata_i,
  // Data bus
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i
);

  fetch_exec_if u_fe_if ();
  regfile_if    u_rf_if ();

  ////////////////////
  // Fetch
  ////////////////////
  fetch_stage u_fetch (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .fe             (u_fe_if.fetch),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i)
  );

  ////////////////////
  // Execute
  ////////////////////
  exec_stage u_exec (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fe            (u_fe_if.exec),
    .rf            (u_rf_if.exec),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i)
  );

  // Registers
  register_file u_rf (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .rf    (u_rf_if.regfile)
  );

endmodule

//--- exec_stage.sv
// Execute stage with decode, ALU, branch resolution, memory access and writeback
`timescale 1ns/10ps

module exec_stage (
  input  logic            clk_i,
  input  logic            rst_i,
  fetch_exec_if.exec      fe,
  regfile_if.exec         rf,
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i
);
  import core_pkg::*;

  decoded_t dec;
  word_t    op_a;
  word_t    op_b;
  word_t    alu_res;
  word_t    link;
  word_t    lsu_rdata;
  logic     is_mem;
  logic     br_taken;
  logic     lsu_start;
  logic     lsu_done;
  logic     busy_q;

  instr_decoder u_dec (
    .instr_i (fe.instr),
    .dec_o   (dec)
  );

  ////////////////////
  // Operands and ALU
  ////////////////////
  assign rf.raddr_a = dec.rs1;
  assign rf.raddr_b = dec.rs2;
  // LUI adds its immediate to zero
  assign op_a = dec.lui ? '0 : rf.rdata_a;
  assign op_b = dec.use_imm ? dec.imm : rf.rdata_b;

  always_comb begin
    case (dec.alu_op)
      ALU_SUB: alu_res = op_a - op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_OR:  alu_res = op_a | op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_res = op_a + op_b;
    endcase
  end

  ////////////////////
  // Control flow
  ////////////////////
  assign br_taken       = dec.branch & ((rf.rdata_a == rf.rdata_b) ^ dec.bne);
  assign link           = fe.pc + word_t'(INSTR_STEP);
  assign fe.redirect    = fe.instr_valid & (br_taken | dec.jal);
  assign fe.redirect_pc = fe.pc + dec.imm;

  // Memory ops held in the buffer until done
  assign is_mem    = dec.load | dec.store;
  assign lsu_start = fe.instr_valid & is_mem & ~busy_q;
  assign fe.take   = fe.instr_valid & (~is_mem | lsu_done);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (lsu_start) begin
      busy_q <= 1'b1;
    end else if (lsu_done) begin
      busy_q <= 1'b0;
    end
  end

  load_store_unit u_lsu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (lsu_start),
    .we_i          (dec.store),
    .addr_i        (alu_res),
    .wdata_i       (rf.rdata_b),
    .done_o        (lsu_done),
    .rdata_o       (lsu_rdata),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i)
  );

  // Writeback in the take cycle
  assign rf.we    = fe.take & dec.we;
  assign rf.waddr = dec.rd;
  assign rf.wdata = dec.load ? lsu_rdata : (dec.jal ? link : alu_res);

  // Fetch must keep the memory instruction buffered
  a_mem_held: assert property (@(posedge clk_i) disable iff (rst_i)
    busy_q |-> fe.instr_valid)
    else $error("Instruction lost during a memory access");

endmodule

//--- fetch_stage.sv
// Fetch stage with PC, instruction bus sequencing and a one-entry buffer
`timescale 1ns/10ps

module fetch_stage (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,
  fetch_exec_if.fetch     fe,
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output core_pkg::word_t instr_addr_o,
  input  core_pkg::word_t instr_rdata_i
);
  import core_pkg::*;

  logic  fetch_en_q;
  logic  outst_q;
  logic  buf_valid_q;
  word_t fetch_addr_q;
  word_t resp_pc_q;
  word_t buf_instr_q;
  word_t buf_pc_q;
  logic  enabled;
  logic  granted;
  logic  accept_rsp;

  // Fetch enable is sticky once seen
  assign enabled    = fetch_enable_i | fetch_en_q;
  // Request only with nothing outstanding and the buffer empty
  assign instr_req_o  = enabled & ~outst_q & ~buf_valid_q;
  assign instr_addr_o = fetch_addr_q;
  assign granted    = instr_req_o & instr_gnt_i;
  // A redirect drops the response of its cycle
  assign accept_rsp = instr_rvalid_i & outst_q & ~fe.redirect;

  assign fe.instr_valid = buf_valid_q;
  assign fe.instr       = buf_instr_q;
  assign fe.pc          = buf_pc_q;

  ////////////////////
  // Control state
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_en_q   <= 1'b0;
      outst_q      <= 1'b0;
      buf_valid_q  <= 1'b0;
      fetch_addr_q <= boot_addr_i;
    end else begin
      if (fetch_enable_i) begin
        fetch_en_q <= 1'b1;
      end
      // Redirect wins over the next sequential address
      if (fe.redirect) begin
        fetch_addr_q <= fe.redirect_pc;
      end else if (granted) begin
        fetch_addr_q <= fetch_addr_q + word_t'(INSTR_STEP);
      end else if (!enabled) begin
        fetch_addr_q <= boot_addr_i;
      end
      // At most one transaction in flight
      if (granted) begin
        outst_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outst_q <= 1'b0;
      end
      // Buffer empties on take or flush
      if (fe.redirect || (buf_valid_q && fe.take)) begin
        buf_valid_q <= 1'b0;
      end else if (accept_rsp) begin
        buf_valid_q <= 1'b1;
      end
    end
  end

  // Buffer payload
  always_ff @(posedge clk_i) begin
    if (granted) begin
      resp_pc_q <= fetch_addr_q;
    end
    if (accept_rsp) begin
      buf_instr_q <= instr_rdata_i;
      buf_pc_q    <= resp_pc_q;
    end
  end

  // Bus allows only one outstanding response
  a_no_req_outst: assert property (@(posedge clk_i) disable iff (rst_i)
    (instr_req_o && instr_gnt_i) |=> !instr_req_o)
    else $error("Instruction request while a response is outstanding");

endmodule

//--- instr_decoder.sv
// Instruction decoder from a raw word to the decoded instruction record
`timescale 1ns/10ps

module instr_decoder (
  input  core_pkg::word_t    instr_i,
  output core_pkg::decoded_t dec_o
);
  import core_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  alu_op_e    f3_alu;
  logic       f3_ok;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  ////////////////////
  // Immediates
  ////////////////////
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};

  // funct3 to ALU op, shared by OP and OP-IMM
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      3'b000:  f3_alu = ALU_ADD;
      3'b010:  f3_alu = ALU_SLT;
      3'b100:  f3_alu = ALU_XOR;
      3'b110:  f3_alu = ALU_OR;
      3'b111:  f3_alu = ALU_AND;
      // Shifts and SLTU not supported
      default: begin
        f3_alu = ALU_ADD;
        f3_ok  = 1'b0;
      end
    endcase
  end

  always_comb begin
    // All flags clear, unknown opcodes run as no-ops
    dec_o        = '0;
    dec_o.rs1    = instr_i[19:15];
    dec_o.rs2    = instr_i[24:20];
    dec_o.rd     = instr_i[11:7];
    dec_o.alu_op = ALU_ADD;
    case (opcode)
      OPC_LUI: begin
        dec_o.imm     = imm_u;
        dec_o.use_imm = 1'b1;
        dec_o.lui     = 1'b1;
        dec_o.we      = 1'b1;
      end
      OPC_OP_IMM: begin
        dec_o.imm     = imm_i;
        dec_o.use_imm = 1'b1;
        dec_o.alu_op  = f3_alu;
        dec_o.we      = f3_ok;
      end
      OPC_OP: begin
        // funct7 bit 5 selects SUB
        dec_o.alu_op = (funct3 == 3'b000 && instr_i[30]) ? ALU_SUB : f3_alu;
        dec_o.we     = f3_ok;
      end
      OPC_LOAD: begin
        dec_o.imm     = imm_i;
        dec_o.use_imm = 1'b1;
        dec_o.load    = 1'b1;
        dec_o.we      = 1'b1;
      end
      OPC_STORE: begin
        dec_o.imm     = imm_s;
        dec_o.use_imm = 1'b1;
        dec_o.store   = 1'b1;
      end
      OPC_BRANCH: begin
        dec_o.imm    = imm_b;
        // BEQ and BNE only
        dec_o.branch = (funct3[2:1] == 2'b00);
        dec_o.bne    = funct3[0];
      end
      OPC_JAL: begin
        dec_o.imm = imm_j;
        dec_o.jal = 1'b1;
        dec_o.we  = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- load_store_unit.sv
// Load/store unit running one word access on the data bus
`timescale 1ns/10ps

module load_store_unit (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            start_i,
  input  logic            we_i,
  input  core_pkg::word_t addr_i,
  input  core_pkg::word_t wdata_i,
  output logic            done_o,
  output core_pkg::word_t rdata_o,
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i
);
  import core_pkg::*;

  typedef enum logic [1:0] {LSU_IDLE, LSU_REQ, LSU_WAIT} lsu_state_e;

  lsu_state_e state_q;
  logic       we_q;
  word_t      addr_q;
  word_t      wdata_q;

  // Request comes from registers, stable until grant
  assign data_req_o   = (state_q == LSU_REQ);
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  // Completion in the rvalid cycle
  assign done_o  = (state_q == LSU_WAIT) & data_rvalid_i;
  assign rdata_o = data_rdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LSU_IDLE;
    end else begin
      case (state_q)
        LSU_IDLE: if (start_i) state_q <= LSU_REQ;
        LSU_REQ:  if (data_gnt_i) state_q <= LSU_WAIT;
        LSU_WAIT: if (data_rvalid_i) state_q <= LSU_IDLE;
        default:  state_q <= LSU_IDLE;
      endcase
    end
  end

  // Capture the access at start
  always_ff @(posedge clk_i) begin
    if (start_i && (state_q == LSU_IDLE)) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o)))
    else $error("Data request dropped or address changed before grant");

  // Execute stage starts one access at a time
  a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |-> (state_q == LSU_IDLE))
    else $error("LSU started while busy");

endmodule

//--- register_file.sv
// Register file with 32 words, two combinational reads and one write port
`timescale 1ns/10ps

module register_file (
  input  logic          clk_i,
  input  logic          rst_i,
  regfile_if.regfile    rf
);
  import core_pkg::*;

  word_t regs [NUM_REGS];

  // Asynchronous read
  assign rf.rdata_a = regs[rf.raddr_a];
  assign rf.rdata_b = regs[rf.raddr_b];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && (rf.waddr != '0)) begin
      // x0 stays hardwired
      regs[rf.waddr] <= rf.wdata;
    end
  end

  a_x0_zero: assert property (@(posedge clk_i) disable iff (rst_i)
    ((rf.raddr_a != '0) || (rf.rdata_a == '0)) &&
    ((rf.raddr_b != '0) || (rf.rdata_b == '0)))
    else $error("Register x0 read back non-zero");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it, and decide pass or fail from the log
LOG=sim.log
verilator --binary --timing --assert --top-module tb_core -o tb_core_sim -f all.f \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_core_sim > "$LOG" 2>&1 || echo "Simulator returned an error status"
cat "$LOG"
grep -qx "Simulation finished: PASS" "$LOG" && exit 0 || exit 1

//--- tb_core.sv
// Testbench for the two-stage core, program and expected stores come from the cases file
`timescale 1ns/10ps

module tb_core;
  import core_pkg::*;

  localparam int CASE_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  // addi x0, x0, 0
  localparam word_t NOP = 32'h0000_0013;
  // Cycles after the last store in which no further store may appear
  localparam int DRAIN = 40;

  logic  clk = 1'b0;
  logic  rst;
  logic  fetch_enable;
  word_t boot_addr;
  logic  instr_req;
  logic  instr_gnt = 1'b0;
  logic  instr_rvalid = 1'b0;
  word_t instr_addr;
  word_t instr_rdata = '0;
  logic  data_req;
  logic  data_gnt = 1'b0;
  logic  data_rvalid = 1'b0;
  logic  data_we;
  word_t data_addr;
  word_t data_wdata;
  word_t data_rdata = '0;

  word_t cases_mem [CASE_WORDS];
  word_t dmem [DMEM_WORDS];
  int    n_prog;
  int    n_st;
  int    limit;
  int    other;
  int    cycles = 0;
  int    stores_seen = 0;
  int    mismatches = 0;
  int    failures = 0;
  logic  file_bad;
  logic  timed_out;
  logic  rst_armed = 1'b0;
  logic  first_fetch;
  word_t rng = 32'h2edef4e1;
  // Bus model state
  logic [1:0] i_gwait;
  logic [1:0] i_rwait;
  logic [1:0] d_gwait;
  logic [1:0] d_rwait;
  logic       i_busy;
  logic       d_busy;
  word_t      i_word;
  word_t      d_word;
  logic       d_hold;
  word_t      d_hold_addr;

  core_top UUT (
    .clk_i          (clk),
    .rst_i          (rst),
    .fetch_enable_i (fetch_enable),
    .boot_addr_i    (boot_addr),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_we_o      (data_we),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_rdata_i   (data_rdata)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Program word at a fetch address, NOP past the end
  function automatic word_t program_word(input word_t addr);
    word_t offs;
    offs = (addr - boot_addr) >> 2;
    if (offs < word_t'(n_prog)) begin
      return cases_mem[8'(3 + int'(offs))];
    end
    return NOP;
  endfunction

  // Field 0 is the address, field 1 the data
  function automatic word_t expected_store(input int k, input int field);
    return cases_mem[8'(3 + n_prog + 2 * k + field)];
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      mismatches++;
    end
  endtask

  ////////////////////
  // Memory models
  ////////////////////
  always @(posedge clk) begin
    if (rst) begin
      if (rst_armed) begin
        check_value("request low in reset", '0, {30'b0, instr_req, data_req});
      end
      rst_armed    <= 1'b1;
      first_fetch  <= 1'b1;
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
      data_gnt     <= 1'b0;
      data_rvalid  <= 1'b0;
      i_busy       <= 1'b0;
      d_busy       <= 1'b0;
      i_gwait      <= 2'd0;
      d_gwait      <= 2'd0;
      d_hold       <= 1'b0;
      stores_seen  <= 0;
      // Fill value tied to the word address
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= ~(word_t'(i) << 2);
      end
    end else begin
      if (!fetch_enable) begin
        check_value("request low while disabled", '0, {30'b0, instr_req, data_req});
      end
      // Instruction side
      instr_rvalid <= 1'b0;
      if (instr_req && instr_gnt) begin
        if (first_fetch) begin
          check_value("first fetch address", boot_addr, instr_addr);
        end
        first_fetch <= 1'b0;
        instr_gnt   <= 1'b0;
        i_busy      <= 1'b1;
        i_word      <= program_word(instr_addr);
        rng = xorshift32(rng);
        i_gwait     <= rng[1:0];
        i_rwait     <= rng[3:2];
      end else if (instr_req) begin
        if (i_gwait == 2'd0) instr_gnt <= 1'b1;
        else i_gwait <= i_gwait - 2'd1;
      end
      if (i_busy) begin
        if (i_rwait == 2'd0) begin
          instr_rvalid <= 1'b1;
          instr_rdata  <= i_word;
          i_busy       <= 1'b0;
        end else begin
          i_rwait <= i_rwait - 2'd1;
        end
      end
      // Data side, request must hold until its grant
      data_rvalid <= 1'b0;
      if (d_hold) begin
        check_value("data request held", 32'd1, {31'b0, data_req});
        check_value("data address held", d_hold_addr, data_addr);
      end
      d_hold      <= data_req && !data_gnt;
      d_hold_addr <= data_addr;
      if (data_req && data_gnt) begin
        if ((data_addr[31:10] != '0) || (data_addr[1:0] != 2'b00)) begin
          $display("Data access to %h is outside the data memory", data_addr);
          failures++;
        end
        data_gnt <= 1'b0;
        d_busy   <= 1'b1;
        d_word   <= dmem[data_addr[9:2]];
        if (data_we) begin
          dmem[data_addr[9:2]] <= data_wdata;
          if (stores_seen < n_st) begin
            check_value($sformatf("store %0d address", stores_seen),
                        expected_store(stores_seen, 0), data_addr);
            check_value($sformatf("store %0d data", stores_seen),
                        expected_store(stores_seen, 1), data_wdata);
          end else begin
            $display("Store of %h to %h came after the last expected store",
                     data_wdata, data_addr);
            failures++;
          end
          stores_seen <= stores_seen + 1;
        end
        rng = xorshift32(rng);
        d_gwait <= rng[1:0];
        d_rwait <= rng[3:2];
      end else if (data_req) begin
        if (d_gwait == 2'd0) data_gnt <= 1'b1;
        else d_gwait <= d_gwait - 2'd1;
      end
      if (d_busy) begin
        if (d_rwait == 2'd0) begin
          data_rvalid <= 1'b1;
          data_rdata  <= d_word;
          d_busy      <= 1'b0;
        end else begin
          d_rwait <= d_rwait - 2'd1;
        end
      end
    end
  end

  ////////////////////
  // Sequence
  ////////////////////
  initial begin
    for (int i = 0; i < CASE_WORDS; i++) begin
      cases_mem[i] = '0;
    end
    $readmemh("core_cases.txt", cases_mem);
    n_prog = int'(cases_mem[1]);
    n_st   = int'(cases_mem[2]);
    file_bad = (n_prog <= 0) || (n_st <= 0) || (3 + n_prog + 2 * n_st > CASE_WORDS);
    if (file_bad) begin
      $display("The cases file core_cases.txt is missing or malformed");
      n_prog = 0;
      n_st   = 0;
    end
    limit = 40 * n_prog + 200;
    rst          <= 1'b1;
    fetch_enable <= 1'b0;
    boot_addr    <= cases_mem[0];
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // Core held disabled for a few cycles after reset
    repeat (4) @(posedge clk);
    fetch_enable <= 1'b1;
    while ((stores_seen < n_st) && (cycles < limit)) begin
      @(posedge clk);
    end
    timed_out = (stores_seen < n_st);
    if (timed_out) begin
      $display("Timeout: the program did not finish within %0d cycles", limit);
    end else begin
      repeat (DRAIN) @(posedge clk);
    end
    other = failures + int'(timed_out) + int'(file_bad);
    $display("Errors: %0d mismatches, %0d other failures, %0d of %0d stores seen",
             mismatches, other, stores_seen, n_st);
    if ((mismatches == 0) && (other == 0)) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
